// ==== src.f ====
design/dma_legalizer_pkg.sv
design/req_decode.sv
design/burst_splitter.sv
design/obi_req_format.sv
design/dma_legalizer.sv
test/dma_legalizer_checker.sv
test/tb_dma_legalizer.sv

// ==== Bender.yml ====
package:
  name: dma_legalizer

sources:
  - design/dma_legalizer_pkg.sv
  - design/req_decode.sv
  - design/burst_splitter.sv
  - design/obi_req_format.sv
  - design/dma_legalizer.sv
  - target: test
    files:
      - test/dma_legalizer_checker.sv
      - test/tb_dma_legalizer.sv

// ==== test/tb_dma_legalizer.sv ====
// --------------------------------------------------------------------------
// Testbench with clock, reset, stimulus, reference bursts, monitor,
// watchdog and closing summary
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_dma_legalizer import dma_legalizer_pkg::*; ();

    localparam time ClkPeriod   = 40ns;
    localparam time DriveDelay  = 2ns;
    localparam int  ResetCycles = 10;
    // 26 requests, at most 12 bursts per side each, 20 cycles per burst
    localparam int  TimeoutCycles = 26 * 12 * 20 + 200;

    logic      clk_i;
    logic      rst_n_i;
    xfer_req_t req_i;
    logic      valid_i;
    logic      ready_o;
    r_req_t    r_req_o;
    logic      r_valid_o;
    logic      r_ready_i;
    w_req_t    w_req_o;
    logic      w_valid_o;
    logic      w_ready_i;
    logic      flush_i;
    logic      kill_i;
    logic      r_busy_o;
    logic      w_busy_o;

    // Expected bursts in issue order, plus a final-burst marker per side
    r_req_t    r_exp_q[$];
    w_req_t    w_exp_q[$];
    bit        r_fin_q[$];
    bit        w_fin_q[$];
    r_req_t    r_exp;
    w_req_t    w_exp;

    integer    seed;
    integer    ready_seed;
    // 0 readies high, 1 random gaps, 2 driven by the test itself
    int        ready_mode;
    string     test_name;
    int        errors;
    int        err_mark;
    int        bursts_seen;
    int        tests_run;
    int        tests_failed;
    xfer_req_t req;

    dma_legalizer i_dma_legalizer (.*);

    bind dma_legalizer dma_legalizer_checker i_dma_legalizer_checker (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .ready_i   ( ready_o   ),
        .r_valid_i ( r_valid_o ),
        .w_valid_i ( w_valid_o ),
        .r_busy_i  ( r_busy_o  ),
        .w_busy_i  ( w_busy_o  ),
        .flush_i   ( flush_i   )
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(ClkPeriod / 2);
            clk_i = ~clk_i;
        end
    end

    // Ready driver with random gaps from a seed of its own
    initial begin
        forever begin
            @(posedge clk_i);
            #(DriveDelay);
            if (ready_mode == 0) begin
                r_ready_i = 1'b1;
                w_ready_i = 1'b1;
            end else if (ready_mode == 1) begin
                r_ready_i = ($random(ready_seed) & 3) != 0;
                w_ready_i = ($random(ready_seed) & 3) != 0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Each burst runs to the next word boundary or to the end of the job
    function automatic void ref_bursts(input xfer_req_t rq);
        addr_t  addr;
        int     left;
        int     off;
        int     n;
        r_req_t r;
        w_req_t w;
        // Read side walks the source
        addr = rq.src_addr;
        left = rq.length;
        while (left > 0) begin
            off           = addr % StrbWidth;
            n             = (left < StrbWidth - off) ? left : StrbWidth - off;
            r             = '0;
            r.a_chan.addr = addr_t'(addr - off);
            r.a_chan.be   = '1;
            r.offset      = offset_t'(off);
            r.tailer      = offset_t'((off + n) % StrbWidth);
            r.shift       = rq.src_addr[OffsetWidth-1:0];
            r.is_single   = 1'b1;
            left          = left - n;
            r_exp_q.push_back(r);
            r_fin_q.push_back(left == 0);
            addr          = addr_t'(addr + n);
        end
        // Write side walks the destination
        addr = rq.dst_addr;
        left = rq.length;
        while (left > 0) begin
            off           = addr % StrbWidth;
            n             = (left < StrbWidth - off) ? left : StrbWidth - off;
            w             = '0;
            w.a_chan.addr = addr_t'(addr - off);
            for (int b = 0; b < StrbWidth; b++) begin
                w.a_chan.be[b] = (b >= off) && (b < off + n);
            end
            w.a_chan.we   = 1'b1;
            w.offset      = offset_t'(off);
            w.tailer      = offset_t'((off + n) % StrbWidth);
            // Negated destination offset, modulo the word
            w.shift       = offset_t'((StrbWidth - rq.dst_addr % StrbWidth) % StrbWidth);
            left          = left - n;
            w.last        = (left == 0);
            w.super_last  = rq.super_last;
            w_exp_q.push_back(w);
            w_fin_q.push_back(left == 0);
            addr          = addr_t'(addr + n);
        end
    endfunction

    function automatic xfer_req_t random_req(input int max_len);
        xfer_req_t rq;
        int        rnd;
        rnd           = $random(seed);
        rq.length     = len_t'(1 + (rnd & 32'h7fff) % max_len);
        rq.src_addr   = addr_t'($random(seed));
        rq.dst_addr   = addr_t'($random(seed));
        rnd           = $random(seed);
        rq.super_last = rnd[0];
        return rq;
    endfunction

    task automatic report_failure(input string what);
        $display("test %s: %s", test_name, what);
        errors++;
    endtask

    // ------------------------------------------------------------------------
    // Monitor
    // ------------------------------------------------------------------------
    // A burst moves at the next rising edge, so sample in mid cycle
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            if (r_valid_o || w_valid_o) begin
                report_failure("a valid output was raised during reset");
            end
        end else begin
            if (flush_i && (r_valid_o || w_valid_o)) begin
                report_failure("a burst was offered while flush_i was high");
            end
            if (flush_i && ready_o) begin
                report_failure("ready_o was high while flush_i was high");
            end
            if ((r_valid_o && !r_busy_o) || (w_valid_o && !w_busy_o)) begin
                report_failure("a valid output was high without its busy");
            end
            if (ready_o && r_busy_o && r_fin_q.size() > 0 && !r_fin_q[0]) begin
                report_failure("ready_o rose before the final read burst");
            end
            if (ready_o && w_busy_o && w_fin_q.size() > 0 && !w_fin_q[0]) begin
                report_failure("ready_o rose before the final write burst");
            end
            if (r_valid_o) begin
                bursts_seen++;
                if (r_exp_q.size() == 0) begin
                    report_failure("a read burst was issued with none expected");
                end else begin
                    r_exp = r_exp_q.pop_front();
                    r_fin_q.delete(0);
                    if (r_req_o !== r_exp) begin
                        $display("error test %s read burst: expected %h, actual %h",
                                 test_name, r_exp, r_req_o);
                        errors++;
                    end
                end
            end
            if (w_valid_o) begin
                bursts_seen++;
                if (w_exp_q.size() == 0) begin
                    report_failure("a write burst was issued with none expected");
                end else begin
                    w_exp = w_exp_q.pop_front();
                    w_fin_q.delete(0);
                    if (w_req_o !== w_exp) begin
                        $display("error test %s write burst: expected %h, actual %h",
                                 test_name, w_exp, w_req_o);
                        errors++;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------
    // Called just after a rising edge, returns just after the accept edge
    task automatic send_req(input xfer_req_t rq);
        logic taken;
        ref_bursts(rq);
        req_i   = rq;
        valid_i = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = ready_o;
            @(posedge clk_i);
            #(DriveDelay);
        end
        valid_i = 1'b0;
    endtask

    // Both sides idle, then every expected burst must have been seen
    task automatic wait_idle();
        do begin
            @(negedge clk_i);
        end while (r_busy_o || w_busy_o);
        if (r_exp_q.size() != 0 || w_exp_q.size() != 0) begin
            report_failure($sformatf("%0d read and %0d write bursts were never issued",
                                     r_exp_q.size(), w_exp_q.size()));
        end
        @(posedge clk_i);
        #(DriveDelay);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - err_mark);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        seed         = 32'hc8ba4154;
        ready_seed   = seed ^ 32'h0000ffff;
        ready_mode   = 2;
        rst_n_i      = 1'b0;
        req_i        = '0;
        valid_i      = 1'b0;
        r_ready_i    = 1'b0;
        w_ready_i    = 1'b0;
        flush_i      = 1'b0;
        kill_i       = 1'b0;
        errors       = 0;
        err_mark     = 0;
        bursts_seen  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        @(posedge clk_i);
        #(DriveDelay);
        // Readies high through the rest of reset while the valids stay low
        r_ready_i    = 1'b1;
        w_ready_i    = 1'b1;
        repeat (ResetCycles - 1) @(posedge clk_i);
        #(DriveDelay);
        rst_n_i    = 1'b1;
        ready_mode = 0;
        @(posedge clk_i);
        #(DriveDelay);

        start_test("aligned");
        @(negedge clk_i);
        if (!ready_o) begin
            report_failure("ready_o stayed low while idle with both readies high");
        end
        @(posedge clk_i);
        #(DriveDelay);
        req.length     = 16;
        req.src_addr   = 24'h000100;
        req.dst_addr   = 24'h000240;
        req.super_last = 1'b1;
        send_req(req);
        wait_idle();
        end_test();

        start_test("unaligned");
        repeat (8) send_req(random_req(32));
        wait_idle();
        end_test();

        // Random gaps on each ready, independently
        start_test("back_pressure");
        ready_mode = 1;
        repeat (6) send_req(random_req(40));
        wait_idle();
        ready_mode = 0;
        r_ready_i  = 1'b1;
        w_ready_i  = 1'b1;
        end_test();

        // Flush lands mid job with the next request waiting
        start_test("flush");
        fork
            begin
                repeat (3) send_req(random_req(40));
            end
            begin
                repeat (3) @(posedge clk_i);
                #(DriveDelay);
                flush_i = 1'b1;
                repeat (6) @(posedge clk_i);
                #(DriveDelay);
                flush_i = 1'b0;
            end
        join
        wait_idle();
        end_test();

        // Readies drop first so no burst moves in the kill cycle
        start_test("kill");
        ready_mode     = 2;
        req            = random_req(40);
        req.length     = 40;
        send_req(req);
        repeat (3) @(posedge clk_i);
        #(DriveDelay);
        r_ready_i = 1'b0;
        w_ready_i = 1'b0;
        @(posedge clk_i);
        #(DriveDelay);
        kill_i = 1'b1;
        @(posedge clk_i);
        #(DriveDelay);
        kill_i = 1'b0;
        @(negedge clk_i);
        if (r_busy_o || w_busy_o) begin
            report_failure("a busy output stayed high after kill_i");
        end
        // Dropped bursts of the killed job
        r_exp_q.delete();
        r_fin_q.delete();
        w_exp_q.delete();
        w_fin_q.delete();
        @(posedge clk_i);
        #(DriveDelay);
        r_ready_i  = 1'b1;
        w_ready_i  = 1'b1;
        ready_mode = 0;
        send_req(random_req(40));
        wait_idle();
        end_test();

        start_test("back_to_back");
        repeat (6) send_req(random_req(12));
        wait_idle();
        end_test();

        $display("tests %0d, failed %0d, bursts checked %0d, errors %0d",
                 tests_run, tests_failed, bursts_seen, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the longest possible run of all tests
    initial begin
        repeat (ResetCycles + TimeoutCycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles in test %s",
                 ResetCycles + TimeoutCycles, test_name);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== test/dma_legalizer_checker.sv ====
// --------------------------------------------------------------------------
// Bound assertions on reset, valid and busy, flush and request handshake
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module dma_legalizer_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic ready_i,
    input logic r_valid_i,
    input logic w_valid_i,
    input logic r_busy_i,
    input logic w_busy_i,
    input logic flush_i
);

    // Both sides stay silent while reset is held
    reset_quiet_a: assert property (@(posedge clk_i)
        !rst_n_i |-> !r_valid_i && !w_valid_i)
        else $error("valid output while reset is held");

    // An offered burst belongs to an active job
    r_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        r_valid_i |-> r_busy_i)
        else $error("read valid without read busy");

    w_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        w_valid_i |-> w_busy_i)
        else $error("write valid without write busy");

    // Flush pauses emission on both sides
    flush_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> !r_valid_i && !w_valid_i)
        else $error("burst offered during flush");

    // No job is taken while flushing
    flush_ready_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> !ready_i)
        else $error("request ready during flush");

endmodule

// ==== design/dma_legalizer.sv ====
// --------------------------------------------------------------------------
// Top level of the 1D legalizer with decoupled read and write sides
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module dma_legalizer import dma_legalizer_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // 1D request
    input  xfer_req_t req_i,
    input  logic      valid_i,
    output logic      ready_o,
    // Read requests
    output r_req_t    r_req_o,
    output logic      r_valid_o,
    input  logic      r_ready_i,
    // Write requests
    output w_req_t    w_req_o,
    output logic      w_valid_o,
    input  logic      w_ready_i,
    // Pause emission, drop the active job
    input  logic      flush_i,
    input  logic      kill_i,
    output logic      r_busy_o,
    output logic      w_busy_o
);

    logic        load;
    side_state_t r_init;
    side_state_t w_init;
    write_side_t w_side_new;
    write_side_t w_side;
    shift_t      shift;
    burst_t      r_burst;
    burst_t      w_burst;
    logic        r_advance;
    logic        w_advance;

    // Each side steps on its own ready
    assign r_advance = (r_ready_i & ~flush_i) | kill_i;
    assign w_advance = (w_ready_i & ~flush_i) | kill_i;

    // Valids follow the readies combinationally
    assign r_valid_o = r_busy_o & r_ready_i & ~flush_i;
    assign w_valid_o = w_busy_o & w_ready_i & ~flush_i;

    req_decode i_req_decode (
        .clk_i     ( clk_i          ),
        .rst_n_i   ( rst_n_i        ),
        .req_i     ( req_i          ),
        .valid_i   ( valid_i        ),
        .ready_o   ( ready_o        ),
        .r_done_i  ( r_burst.done   ),
        .w_done_i  ( w_burst.done   ),
        .r_ready_i ( r_ready_i      ),
        .w_ready_i ( w_ready_i      ),
        .flush_i   ( flush_i        ),
        .load_o    ( load           ),
        .r_init_o  ( r_init         ),
        .w_init_o  ( w_init         ),
        .w_side_o  ( w_side_new     ),
        .shift_o   ( shift          )
    );

    burst_splitter #(.side_payload_t(read_side_t)) i_read_splitter (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .load_i    ( load      ),
        .init_i    ( r_init    ),
        .payload_i ( '0        ),
        .advance_i ( r_advance ),
        .kill_i    ( kill_i    ),
        .burst_o   ( r_burst   ),
        .payload_o (           ),
        .busy_o    ( r_busy_o  )
    );

    burst_splitter #(.side_payload_t(write_side_t)) i_write_splitter (
        .clk_i     ( clk_i      ),
        .rst_n_i   ( rst_n_i    ),
        .load_i    ( load       ),
        .init_i    ( w_init     ),
        .payload_i ( w_side_new ),
        .advance_i ( w_advance  ),
        .kill_i    ( kill_i     ),
        .burst_o   ( w_burst    ),
        .payload_o ( w_side     ),
        .busy_o    ( w_busy_o   )
    );

    obi_req_format i_obi_req_format (
        .r_burst_i ( r_burst ),
        .w_burst_i ( w_burst ),
        .shift_i   ( shift   ),
        .w_side_i  ( w_side  ),
        .r_req_o   ( r_req_o ),
        .w_req_o   ( w_req_o )
    );

endmodule

// ==== design/obi_req_format.sv ====
// --------------------------------------------------------------------------
// Read and write OBI request structs with their data-path fields
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module obi_req_format import dma_legalizer_pkg::*; (
    input  burst_t      r_burst_i,
    input  burst_t      w_burst_i,
    input  shift_t      shift_i,
    input  write_side_t w_side_i,
    output r_req_t      r_req_o,
    output w_req_t      w_req_o
);

    // End position of each burst within its word
    burst_len_t r_end;
    burst_len_t w_end;
    logic [StrbWidth-1:0] w_be;

    assign r_end = r_burst_i.num_bytes + burst_len_t'(r_burst_i.offset);
    assign w_end = w_burst_i.num_bytes + burst_len_t'(w_burst_i.offset);

    // Write strobes cover offset up to offset + num_bytes
    always_comb begin
        for (int unsigned i = 0; i < StrbWidth; i++) begin
            w_be[i] = (burst_len_t'(i) >= burst_len_t'(w_burst_i.offset)) &&
                      (burst_len_t'(i) < w_end);
        end
    end

    // ------------------------------------------------------------------------
    // Read request
    // ------------------------------------------------------------------------
    // Whole word is fetched, data path picks the bytes
    assign r_req_o.a_chan = '{
        addr:  {r_burst_i.addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}},
        be:    '1,
        we:    1'b0,
        wdata: '0
    };
    assign r_req_o.offset    = r_burst_i.offset;
    // Wraps to 0 for a burst that reaches the word end
    assign r_req_o.tailer    = r_end[OffsetWidth-1:0];
    assign r_req_o.shift     = shift_i.read_shift;
    // Every burst on a single-word bus is one beat
    assign r_req_o.is_single = 1'b1;

    // ------------------------------------------------------------------------
    // Write request
    // ------------------------------------------------------------------------
    assign w_req_o.a_chan = '{
        addr:  {w_burst_i.addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}},
        be:    w_be,
        we:    1'b1,
        wdata: '0
    };
    assign w_req_o.offset = w_burst_i.offset;
    assign w_req_o.tailer = w_end[OffsetWidth-1:0];
    assign w_req_o.shift  = shift_i.write_shift;

    // Final burst of this 1D job
    assign w_req_o.last       = w_burst_i.done;
    // Job end flag from the midend
    assign w_req_o.super_last = w_side_i.super_last;

endmodule

// ==== design/burst_splitter.sv ====
// --------------------------------------------------------------------------
// One side's remaining transfer, cut into single-word bursts
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module burst_splitter import dma_legalizer_pkg::*; #(
    // Extra per-side fields held alongside the transfer
    parameter type side_payload_t = read_side_t
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    // New job from the decoder
    input  logic          load_i,
    input  side_state_t   init_i,
    input  side_payload_t payload_i,
    // Step to the next burst, or drop the job
    input  logic          advance_i,
    input  logic          kill_i,
    // Current burst
    output burst_t        burst_o,
    output side_payload_t payload_o,
    output logic          busy_o
);

    side_state_t   state_q;
    side_state_t   state_d;
    side_payload_t payload_q;

    offset_t    offset;
    burst_len_t to_boundary;
    burst_len_t num_bytes;
    logic       fits;

    // ------------------------------------------------------------------------
    // Word boundary split
    // ------------------------------------------------------------------------
    assign offset      = state_q.addr[OffsetWidth-1:0];
    // Bytes left in the current word, 1 up to StrbWidth
    assign to_boundary = burst_len_t'(StrbWidth) - burst_len_t'(offset);
    // Remainder ends inside this word
    assign fits        = state_q.length <= len_t'(to_boundary);
    assign num_bytes   = fits ? burst_len_t'(state_q.length) : to_boundary;

    always_comb begin
        state_d = state_q;
        if (load_i) begin
            // Load wins over kill
            state_d = init_i;
        end else if (kill_i) begin
            state_d = '0;
        end else if (fits) begin
            // Final burst leaves the side idle
            state_d.valid = 1'b0;
        end else begin
            state_d.length = state_q.length - len_t'(to_boundary);
            state_d.addr   = state_q.addr + addr_t'(to_boundary);
        end
    end

    // ------------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= '0;
        end else if (load_i || advance_i) begin
            state_q <= state_d;
        end
    end

    // Payload of the active job, taken on load
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            payload_q <= payload_i;
        end
    end

    // Idle and kill both count as done so a new job can load
    assign burst_o = '{
        addr:      state_q.addr,
        offset:    offset,
        num_bytes: num_bytes,
        done:      fits | ~state_q.valid | kill_i
    };

    assign payload_o = payload_q;
    assign busy_o    = state_q.valid;

endmodule

// ==== design/req_decode.sv ====
// --------------------------------------------------------------------------
// Request acceptance, initial side states and shift amounts
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module req_decode import dma_legalizer_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // Incoming transfer
    input  xfer_req_t   req_i,
    input  logic        valid_i,
    output logic        ready_o,
    // Side status and flow control
    input  logic        r_done_i,
    input  logic        w_done_i,
    input  logic        r_ready_i,
    input  logic        w_ready_i,
    input  logic        flush_i,
    // Splitter load
    output logic        load_o,
    output side_state_t r_init_o,
    output side_state_t w_init_o,
    output write_side_t w_side_o,
    output shift_t      shift_o
);

    offset_t src_off;
    offset_t dst_off;
    shift_t  shift_q;

    assign src_off = req_i.src_addr[OffsetWidth-1:0];
    assign dst_off = req_i.dst_addr[OffsetWidth-1:0];

    // Take a new job only once both sides show their final burst
    assign ready_o = r_done_i & w_done_i & r_ready_i & w_ready_i & ~flush_i;
    assign load_o  = ready_o & valid_i;

    // Source side starts at src_addr
    assign r_init_o = '{valid: 1'b1, addr: req_i.src_addr, length: req_i.length};
    // Destination side starts at dst_addr
    assign w_init_o = '{valid: 1'b1, addr: req_i.dst_addr, length: req_i.length};

    // Write payload, captured by the write splitter on load
    assign w_side_o = '{super_last: req_i.super_last};

    // Shift amounts of the active job
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            shift_q <= '0;
        end else if (load_o) begin
            // Read data rotates down by the source offset
            shift_q.read_shift  <= src_off;
            // Write data rotates up to the destination offset
            shift_q.write_shift <= offset_t'(-dst_off);
        end
    end

    assign shift_o = shift_q;

endmodule

// ==== design/dma_legalizer_pkg.sv ====
// --------------------------------------------------------------------------
// Widths, address and length types, side state and request structs
// for the single-word OBI transfer legalizer
// --------------------------------------------------------------------------

package dma_legalizer_pkg;

    // Bus geometry
    localparam int unsigned DataWidth     = 32;
    localparam int unsigned StrbWidth     = DataWidth / 8;
    localparam int unsigned OffsetWidth   = $clog2(StrbWidth);
    localparam int unsigned AddrWidth     = 24;
    localparam int unsigned LenWidth      = 16;
    // Holds 0 up to StrbWidth bytes
    localparam int unsigned BurstLenWidth = OffsetWidth + 1;

    typedef logic [AddrWidth-1:0]     addr_t;
    typedef logic [LenWidth-1:0]      len_t;
    typedef logic [OffsetWidth-1:0]   offset_t;
    typedef logic [BurstLenWidth-1:0] burst_len_t;

    // Incoming 1D transfer
    typedef struct packed {
        len_t  length;
        addr_t src_addr;
        addr_t dst_addr;
        logic  super_last;
    } xfer_req_t;

    // Read side carries nothing beyond its state
    typedef struct packed {
        logic rsvd;
    } read_side_t;

    // Write side keeps the end-of-job marker
    typedef struct packed {
        logic super_last;
    } write_side_t;

    // Remaining part of one side's transfer
    typedef struct packed {
        logic  valid;
        addr_t addr;
        len_t  length;
    } side_state_t;

    // Current single-word burst of one side
    typedef struct packed {
        addr_t      addr;
        offset_t    offset;
        burst_len_t num_bytes;
        logic       done;
    } burst_t;

    // Separate shifter amounts for read and write data paths
    typedef struct packed {
        offset_t read_shift;
        offset_t write_shift;
    } shift_t;

    // OBI address channel, word aligned
    typedef struct packed {
        addr_t                addr;
        logic [StrbWidth-1:0] be;
        logic                 we;
        logic [DataWidth-1:0] wdata;
    } obi_a_chan_t;

    typedef struct packed {
        obi_a_chan_t a_chan;
        offset_t     offset;
        offset_t     tailer;
        offset_t     shift;
        logic        is_single;
    } r_req_t;

    typedef struct packed {
        obi_a_chan_t a_chan;
        offset_t     offset;
        offset_t     tailer;
        offset_t     shift;
        logic        last;
        logic        super_last;
    } w_req_t;

endpackage
